// File: dac_ctrl_top.f
verilog/dac_ctrl_pkg.sv
verilog/cal_table.sv
verilog/cmd_sequencer.sv
verilog/dac_value_pipe.sv
verilog/dac_spi_tx.sv
verilog/dac_ctrl_top.sv
verification/tb_clock_gen.sv
verification/dac_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DAC controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f dac_ctrl_top.f --top-module dac_ctrl_tb -o sim_dac_ctrl

sim_out=$(./obj_dir/sim_dac_ctrl)
echo "$sim_out"

# Exit status follows the pass line
echo "$sim_out" | grep -q '\*\*\* TEST PASSED \*\*\*'

// File: verification/dac_ctrl_tb.sv
`timescale 1ns/1ps

module dac_ctrl_tb;
  import dac_ctrl_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WAIT_LIMIT     = 2000; // Cycles allowed for each wait
  localparam int QUIET_CYCLES   = 300;  // Window with no frames or ldac after an error
  localparam int F_TRIG_WAIT    = 0;    // Selectors for wait_flag
  localparam int F_NOT_WAIT     = 1;
  localparam int F_CAL_OOB      = 2;
  localparam int F_VAL_OOB      = 3;
  localparam int F_UNEXP_TRIG   = 4;
  localparam int F_UNDERFLOW    = 5;

  logic           clk;
  logic           resetn;
  logic           reset_req;
  cmd_word_t      cmd_word = '0;      // Head of the buffer
  logic           cmd_buf_empty = 1'b1;
  logic           cmd_word_rd_en;
  logic           trigger;
  logic           ldac_shared;
  logic           waiting_for_trig;
  logic           cmd_buf_underflow;
  logic           unexp_trig;
  logic           cal_oob;
  logic           dac_val_oob;
  abs_val_t [7:0] abs_dac_val_concat;
  logic           n_cs;
  logic           mosi;
  logic           ldac;

  logic [31:0]        buf_q[$];    // Command buffer model
  logic               rd_seen;
  logic [23:0]        frames[$];   // Captured SPI words
  logic [23:0]        cur_frame;
  int                 bit_cnt;
  int                 ldac_cnt;
  int                 cycles;
  int                 err_cnt;
  int                 check_cnt;
  logic [31:0]        lfsr;
  logic [15:0]        raw_vals[8]; // Raw offset codes of the next write
  logic signed [15:0] cal_set[8];  // Calibration the DUT should hold

  tb_clock_gen clock_gen_i (
    .reset_req (reset_req),
    .clk       (clk),
    .resetn    (resetn)
  );

  dac_ctrl_top dac_ctrl_top_i (
    .clk                (clk),
    .resetn             (resetn),
    .cmd_word           (cmd_word),
    .cmd_buf_empty      (cmd_buf_empty),
    .cmd_word_rd_en     (cmd_word_rd_en),
    .trigger            (trigger),
    .ldac_shared        (ldac_shared),
    .waiting_for_trig   (waiting_for_trig),
    .cmd_buf_underflow  (cmd_buf_underflow),
    .unexp_trig         (unexp_trig),
    .cal_oob            (cal_oob),
    .dac_val_oob        (dac_val_oob),
    .abs_dac_val_concat (abs_dac_val_concat),
    .n_cs               (n_cs),
    .mosi               (mosi),
    .ldac               (ldac)
  );

  // Pop seen at the rising edge, next word shows on the falling edge
  always @(posedge clk) rd_seen <= cmd_word_rd_en;

  always @(negedge clk) begin
    if (rd_seen && buf_q.size() > 0) void'(buf_q.pop_front());
    cmd_buf_empty = (buf_q.size() == 0);
    cmd_word = cmd_buf_empty ? cmd_word_t'(32'd0) : cmd_word_t'(buf_q[0]);
  end

  // SPI capture, ldac count and run limit
  always @(posedge clk) begin
    if (!resetn) begin
      bit_cnt = 0;
    end else if (!n_cs) begin
      cur_frame = {cur_frame[22:0], mosi}; // MSB first
      bit_cnt = bit_cnt + 1;
    end else if (bit_cnt != 0) begin
      if (bit_cnt != SPI_FRAME_BITS) begin
        err_cnt++;
        $display("n_cs was low for %0d cycles instead of %0d", bit_cnt, SPI_FRAME_BITS);
      end
      frames.push_back(cur_frame);
      bit_cnt = 0;
    end
    if (resetn && ldac) ldac_cnt++;
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Galois LFSR stepped once for each bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] make_word(input logic [1:0] op, input logic trig,
                                            input logic cont, input logic ld,
                                            input logic [25:0] payload);
    return {op, trig, cont, ld, 1'b0, payload};
  endfunction

  function automatic logic flag_of(input int sel);
    case (sel)
      F_TRIG_WAIT:  return waiting_for_trig;
      F_NOT_WAIT:   return !waiting_for_trig;
      F_CAL_OOB:    return cal_oob;
      F_VAL_OOB:    return dac_val_oob;
      F_UNEXP_TRIG: return unexp_trig;
      default:      return cmd_buf_underflow;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("mismatch %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("ERROR: %s", msg);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    buf_q.delete();
    @(negedge clk);
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    @(negedge clk);
    while (!resetn) @(negedge clk);
    frames.delete();
    ldac_cnt = 0;
    for (int i = 0; i < 8; i++) cal_set[i] = '0; // Table clears on reset
  endtask

  task automatic wait_flag(input int sel, input string name);
    int waited;
    waited = 0;
    while (!flag_of(sel) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!flag_of(sel)) report_failure({name, ": expected level never came"});
  endtask

  task automatic wait_ldac(input int n, input string name);
    int waited;
    waited = 0;
    while (ldac_cnt < n && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ldac_cnt < n) report_failure({name, ": ldac pulse never came"});
  endtask

  // DAC_WR word plus four pair words with the even channel in the low half
  task automatic queue_dac_wr(input logic [25:0] delay);
    buf_q.push_back(make_word(2'd1, 1'b0, 1'b0, 1'b1, delay));
    for (int p = 0; p < 4; p++) buf_q.push_back({raw_vals[2*p+1], raw_vals[2*p]});
  endtask

  task automatic pulse_trigger();
    @(negedge clk);
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
  endtask

  // Frames, one ldac and the concat checked against r - 32767 + c
  task automatic check_dac_wr(input string name);
    int sig;
    logic [15:0] code;
    wait_ldac(1, name);
    check_val({name, " frames"}, 32'd8, 32'(frames.size()));
    for (int i = 0; i < 8; i++) begin
      sig = int'(raw_vals[i]) - 32767 + int'(cal_set[i]);
      code = 16'(sig + 32767);
      if (i < frames.size()) check_val({name, " frame"}, {8'd0, 4'b0001, 1'b0, 3'(i), code},
                                       {8'd0, frames[i]});
      check_val({name, " abs"}, 32'((sig < 0) ? -sig : sig), 32'(abs_dac_val_concat[i]));
    end
    repeat (40) @(negedge clk);
    check_val({name, " ldac count"}, 32'd1, 32'(ldac_cnt));
  endtask

  task automatic expect_quiet(input string name);
    repeat (QUIET_CYCLES) @(negedge clk);
    check_val({name, " frames"}, 32'd0, 32'(frames.size()));
    check_val({name, " ldac count"}, 32'd0, 32'(ldac_cnt));
  endtask

  task automatic test_reset_state();
    check_val("reset n_cs", 32'd1, 32'(n_cs));
    check_val("reset ldac", 32'd0, 32'(ldac));
    check_val("reset rd_en", 32'd0, 32'(cmd_word_rd_en));
    check_val("reset waiting", 32'd0, 32'(waiting_for_trig));
    check_val("reset flags", 32'd0, {28'd0, cmd_buf_underflow, unexp_trig, cal_oob, dac_val_oob});
    for (int i = 0; i < 8; i++) check_val("reset concat", 32'd0, 32'(abs_dac_val_concat[i]));
  endtask

  task automatic test_plain_write();
    reset_dut();
    for (int i = 0; i < 8; i++) begin
      raw_vals[i] = 16'(rand_bits(16));
      if (raw_vals[i] == 16'hFFFF) raw_vals[i] = 16'hFFFE; // Illegal code
    end
    @(posedge clk);
    queue_dac_wr(26'd10);
    check_dac_wr("plain_write");
  endtask

  task automatic test_cal_write();
    reset_dut();
    cal_set[1] = 16'sd100;
    cal_set[2] = -16'sd4096;
    cal_set[5] = 16'sd4096;
    cal_set[6] = -16'sd1234;
    for (int i = 0; i < 8; i++) raw_vals[i] = 16'(rand_bits(15)) + 16'd8192; // No overflow
    @(posedge clk);
    for (int i = 1; i < 7; i++) begin
      if (cal_set[i] != 0)
        buf_q.push_back(make_word(2'd2, 1'b0, 1'b0, 1'b0, {7'd0, 3'(i), cal_set[i]}));
    end
    queue_dac_wr(26'd4);
    check_dac_wr("cal_write");
  endtask

  task automatic test_trigger_wait();
    reset_dut();
    @(posedge clk);
    buf_q.push_back(make_word(2'd0, 1'b1, 1'b0, 1'b1, 26'd0));
    wait_flag(F_TRIG_WAIT, "trigger wait");
    pulse_trigger();
    wait_ldac(1, "trigger wait");
    check_val("trigger waiting", 32'd0, 32'(waiting_for_trig)); // Wait over
    @(posedge clk);
    buf_q.push_back(make_word(2'd0, 1'b1, 1'b0, 1'b1, 26'd0));
    wait_flag(F_TRIG_WAIT, "cancel wait");
    @(posedge clk);
    buf_q.push_back(make_word(2'd3, 1'b0, 1'b0, 1'b0, 26'd0));
    wait_flag(F_NOT_WAIT, "cancel wait");
    repeat (20) @(negedge clk);
    check_val("cancel ldac count", 32'd1, 32'(ldac_cnt)); // Only the triggered one
    check_val("cancel unexp_trig", 32'd0, 32'(unexp_trig));
  endtask

  task automatic test_errors();
    for (int i = 0; i < 8; i++) raw_vals[i] = 16'd32767 + 16'(i);
    reset_dut(); // Calibration over the bound
    @(posedge clk);
    buf_q.push_back(make_word(2'd2, 1'b0, 1'b0, 1'b0, {7'd0, 3'd0, 16'sd5000}));
    queue_dac_wr(26'd0);
    wait_flag(F_CAL_OOB, "cal_oob");
    expect_quiet("cal_oob");
    reset_dut(); // Raw code 0xFFFF in the first pair
    raw_vals[0] = 16'hFFFF;
    @(posedge clk);
    queue_dac_wr(26'd0);
    wait_flag(F_VAL_OOB, "dac_val_oob");
    expect_quiet("dac_val_oob");
    raw_vals[0] = 16'd32767;
    reset_dut(); // Trigger while idle
    pulse_trigger();
    wait_flag(F_UNEXP_TRIG, "unexp_trig");
    @(posedge clk);
    queue_dac_wr(26'd0);
    expect_quiet("unexp_trig");
    reset_dut(); // cont set with nothing behind it
    @(posedge clk);
    buf_q.push_back(make_word(2'd0, 1'b0, 1'b1, 1'b1, 26'd5));
    wait_flag(F_UNDERFLOW, "underflow");
    @(posedge clk);
    queue_dac_wr(26'd0); // Late write must stay blocked
    expect_quiet("underflow");
  endtask

  initial begin
    reset_req   = 1'b0;
    trigger     = 1'b0;
    ldac_shared = 1'b0;
    lfsr        = 32'hb04b_f69a;
    cycles      = 0;
    err_cnt     = 0;
    check_cnt   = 0;
    ldac_cnt    = 0;
    bit_cnt     = 0;
    cur_frame   = '0;
    for (int i = 0; i < 8; i++) cal_set[i] = '0;
    @(negedge clk);
    while (!resetn) @(negedge clk);
    test_reset_state();
    test_plain_write();
    test_cal_write();
    test_trigger_wait();
    test_errors();
    $display("Checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic reset_req, // Sampled on the rising edge, restarts the reset
  output logic clk,
  output logic resetn
);
  logic [2:0] rst_cnt; // Reset cycles left

  initial begin
    clk     = 1'b0;
    resetn  = 1'b0;
    rst_cnt = 3'd5;
  end

  always #50 clk = ~clk; // 100 ns period

  always @(posedge clk) begin
    if (reset_req) rst_cnt <= 3'd5;
    else if (rst_cnt != 3'd0) rst_cnt <= rst_cnt - 3'd1;
  end

  // Reset moves on the falling edge like the other inputs
  always @(negedge clk) resetn = (rst_cnt == 3'd0);

endmodule

// File: verilog/cal_table.sv
`timescale 1ns/1ps

module cal_table #(
  parameter int ABS_CAL_MAX = 4096 // Largest calibration magnitude
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  dac_ctrl_pkg::cal_wr_t    cal_wr,
  output dac_ctrl_pkg::cal_table_t cal_vals,
  output logic                     cal_oob
);
  import dac_ctrl_pkg::*;

  logic in_bound;

  // Signed compare against +/- ABS_CAL_MAX
  assign in_bound = (int'(cal_wr.value) <= ABS_CAL_MAX)
                    && (int'(cal_wr.value) >= -ABS_CAL_MAX);

  // Kept through the error state, only reset clears it
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cal_vals <= '0;
      cal_oob  <= 1'b0;
    end else if (cal_wr.valid) begin
      if (in_bound) begin
        cal_vals[cal_wr.chan] <= cal_wr.value;
      end else begin
        cal_oob <= 1'b1; // Rejected value, table unchanged
      end
    end
  end

endmodule

// File: verilog/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                    clk,
  input  logic                    resetn,
  input  dac_ctrl_pkg::cmd_word_t cmd_word,
  input  logic                    cmd_buf_empty,
  input  logic                    trigger,
  input  logic                    ldac_shared,
  input  logic                    pair_req,
  input  logic                    dac_wr_done,
  input  logic                    cal_oob,
  input  logic                    dac_val_oob,
  output logic                    cmd_word_rd_en,
  output logic                    dac_wr_start,
  output dac_ctrl_pkg::cal_wr_t   cal_wr,
  output logic                    in_error,
  output logic                    waiting_for_trig,
  output logic                    ldac,
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig
);
  import dac_ctrl_pkg::*;

  seq_state_e state;
  seq_state_e next_cmd_state;
  delay_t     delay_timer;
  logic       do_ldac;     // Latched command bits
  logic       wait_trig;
  logic       expect_next;
  logic       word_ok;
  logic       is_wait_cmd; // NOP or DAC_WR, the commands that carry flags
  logic       cancel_wait;
  logic       cmd_done;
  logic       next_cmd;
  logic       underflow;
  logic       bad_trig;
  logic       error;

  assign word_ok     = !cmd_buf_empty;
  assign is_wait_cmd = (cmd_word.op == CMD_NOP) || (cmd_word.op == CMD_DAC_WR);

  // A cancel word cuts a delay, a trigger wait or a finished write short
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT
                        || (state == S_DAC_WR && dac_wr_done))
                       && word_ok && cmd_word.op == CMD_CANCEL;

  assign cmd_done = (state == S_IDLE && word_ok)
                    || (state == S_DELAY && delay_timer == '0)
                    || (state == S_TRIG_WAIT && trigger)
                    || (state == S_DAC_WR && dac_wr_done && !wait_trig && delay_timer == '0);
  assign next_cmd = cmd_done && word_ok; // Word accepted this cycle

  // Where the word at the head of the buffer takes us
  always_comb begin
    if (!word_ok) begin
      next_cmd_state = expect_next ? S_ERROR : S_IDLE;
    end else begin
      case (cmd_word.op)
        CMD_NOP:    next_cmd_state = cmd_word.trig ? S_TRIG_WAIT : S_DELAY;
        CMD_DAC_WR: next_cmd_state = S_DAC_WR;
        default:    next_cmd_state = S_IDLE; // SET_CAL and CANCEL finish at once
      endcase
    end
  end

  // Error sources
  assign underflow = ((cmd_done && expect_next) || pair_req) && cmd_buf_empty;
  assign bad_trig  = (state != S_TRIG_WAIT && trigger) || (state == S_DAC_WR && ldac_shared);
  assign error     = underflow || bad_trig || cal_oob || dac_val_oob;

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_IDLE;
    else if (error) state <= S_ERROR;
    else if (cancel_wait) state <= S_IDLE;
    else if (cmd_done) state <= next_cmd_state;
    else if (state == S_DAC_WR && dac_wr_done) state <= wait_trig ? S_TRIG_WAIT : S_DELAY;
  end

  // Command bits, cleared by anything but NOP or DAC_WR
  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (next_cmd || cancel_wait) begin
      do_ldac     <= is_wait_cmd && cmd_word.ldac;
      wait_trig   <= is_wait_cmd && cmd_word.trig;
      expect_next <= is_wait_cmd && cmd_word.cont;
    end
  end

  // Delay counts down from the accept cycle, also during a DAC write
  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      delay_timer <= '0;
    end else if (next_cmd && is_wait_cmd && !cmd_word.trig) begin
      delay_timer <= cmd_word.payload;
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  // One cycle load pulse after the command ends, never from IDLE or a cancel
  always_ff @(posedge clk) begin
    if (!resetn || in_error) ldac <= 1'b0;
    else ldac <= cmd_done && do_ldac && state != S_IDLE && !cancel_wait && !error;
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      if (bad_trig) unexp_trig <= 1'b1; // Stray trigger or shared ldac mid write
      if (underflow) cmd_buf_underflow <= 1'b1;
    end
  end

  assign cmd_word_rd_en   = !in_error && word_ok && (pair_req || cmd_done || cancel_wait);
  assign dac_wr_start     = next_cmd && cmd_word.op == CMD_DAC_WR && !error;
  assign cal_wr.valid     = next_cmd && cmd_word.op == CMD_SET_CAL;
  assign cal_wr.chan      = cmd_word.payload[18:16];
  assign cal_wr.value     = cmd_word.payload[15:0];
  assign in_error         = (state == S_ERROR);
  assign waiting_for_trig = (state == S_TRIG_WAIT);

endmodule

// File: verilog/dac_ctrl_pkg.sv
package dac_ctrl_pkg;

  // Opcode in bits 31:30 of a command word
  typedef enum logic [1:0] {
    CMD_NOP     = 2'd0, // Delay or trigger wait
    CMD_DAC_WR  = 2'd1, // Write all eight channels, four pair words follow
    CMD_SET_CAL = 2'd2, // Load one calibration register
    CMD_CANCEL  = 2'd3  // End a wait without ldac
  } cmd_op_e;

  typedef logic [2:0]         dac_chan_t;
  typedef logic [15:0]        dac_code_t; // Offset coded, 32767 is zero
  typedef logic signed [15:0] cal_val_t;
  typedef logic [14:0]        abs_val_t;  // Magnitude of a signed DAC value
  typedef logic [25:0]        delay_t;

  typedef struct packed {
    cmd_op_e     op;
    logic        trig;    // Wait for trigger instead of delay
    logic        cont;    // Another command must follow
    logic        ldac;    // Pulse ldac when the command ends
    logic        spare;
    logic [25:0] payload; // Delay count, or channel 18:16 and value 15:0 for SET_CAL
  } cmd_word_t;

  // Calibration register write
  typedef struct packed {
    logic      valid;
    dac_chan_t chan;
    cal_val_t  value;
  } cal_wr_t;

  // One signed calibration value per channel, channel 7 on top
  typedef cal_val_t [7:0] cal_table_t;

  // AD5676 style 24-bit SPI word
  typedef struct packed {
    logic [3:0] cmd;
    logic       zero;
    dac_chan_t  chan;
    dac_code_t  value;
  } spi_frame_t;

  localparam logic [3:0] SPI_CMD_REG_WRITE = 4'b0001; // Write input register, wait for ldac
  localparam int         SPI_FRAME_BITS    = 24;
  localparam dac_code_t  DAC_MID           = 16'd32767; // Offset code of zero

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_DAC_WR,
    S_ERROR // Left only by reset
  } seq_state_e;

endpackage

// File: verilog/dac_ctrl_top.sv
`timescale 1ns/1ps

module dac_ctrl_top #(
  parameter int ABS_CAL_MAX    = 4096, // Calibration bound
  parameter int CS_HIGH_CYCLES = 18    // SPI chip-select spacing
) (
  input  logic                         clk,
  input  logic                         resetn,
  input  dac_ctrl_pkg::cmd_word_t      cmd_word,
  input  logic                         cmd_buf_empty,
  output logic                         cmd_word_rd_en,
  input  logic                         trigger,
  input  logic                         ldac_shared,
  output logic                         waiting_for_trig,
  output logic                         cmd_buf_underflow,
  output logic                         unexp_trig,
  output logic                         cal_oob,
  output logic                         dac_val_oob,
  output dac_ctrl_pkg::abs_val_t [7:0] abs_dac_val_concat, // Channel 7 on top
  output logic                         n_cs,
  output logic                         mosi,
  output logic                         ldac
);
  import dac_ctrl_pkg::*;

  logic           in_error;
  logic           dac_wr_start;
  logic           pair_req;
  logic           dac_wr_done;
  logic           frames_load;
  logic           frame_done;
  cal_wr_t        cal_wr;
  cal_table_t     cal_vals;
  spi_frame_t     frame_a;
  spi_frame_t     frame_b;
  abs_val_t [7:0] abs_vals;

  cmd_sequencer cmd_sequencer_i (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .trigger           (trigger),
    .ldac_shared       (ldac_shared),
    .pair_req          (pair_req),
    .dac_wr_done       (dac_wr_done),
    .cal_oob           (cal_oob),
    .dac_val_oob       (dac_val_oob),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .dac_wr_start      (dac_wr_start),
    .cal_wr            (cal_wr),
    .in_error          (in_error),
    .waiting_for_trig  (waiting_for_trig),
    .ldac              (ldac),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig)
  );

  cal_table #(
    .ABS_CAL_MAX (ABS_CAL_MAX)
  ) cal_table_i (
    .clk      (clk),
    .resetn   (resetn),
    .cal_wr   (cal_wr),
    .cal_vals (cal_vals),
    .cal_oob  (cal_oob)
  );

  dac_value_pipe dac_value_pipe_i (
    .clk           (clk),
    .resetn        (resetn),
    .in_error      (in_error),
    .cmd_word      (cmd_word), // Pair words come through the same port
    .cmd_buf_empty (cmd_buf_empty),
    .dac_wr_start  (dac_wr_start),
    .cal_vals      (cal_vals),
    .frame_done    (frame_done),
    .pair_req      (pair_req),
    .frames_load   (frames_load),
    .frame_a       (frame_a),
    .frame_b       (frame_b),
    .dac_wr_done   (dac_wr_done),
    .abs_vals      (abs_vals),
    .dac_val_oob   (dac_val_oob)
  );

  dac_spi_tx #(
    .CS_HIGH_CYCLES (CS_HIGH_CYCLES)
  ) dac_spi_tx_i (
    .clk         (clk),
    .resetn      (resetn),
    .in_error    (in_error),
    .frames_load (frames_load),
    .frame_a     (frame_a),
    .frame_b     (frame_b),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .frame_done  (frame_done)
  );

  // Snapshot of the loaded values, follows ldac by one cycle
  always_ff @(posedge clk) begin
    if (!resetn || in_error) abs_dac_val_concat <= '0;
    else if (ldac) abs_dac_val_concat <= abs_vals;
  end

endmodule

// File: verilog/dac_spi_tx.sv
`timescale 1ns/1ps

module dac_spi_tx #(
  parameter int CS_HIGH_CYCLES = 18 // Extra n_cs high cycles between frames
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     in_error,
  input  logic                     frames_load,
  input  dac_ctrl_pkg::spi_frame_t frame_a,
  input  dac_ctrl_pkg::spi_frame_t frame_b,
  output logic                     n_cs,
  output logic                     mosi,
  output logic                     frame_done
);
  import dac_ctrl_pkg::*;

  localparam int TIMER_W = $clog2(CS_HIGH_CYCLES + 2);
  localparam int BIT_W   = $clog2(SPI_FRAME_BITS);

  logic [TIMER_W-1:0]          cs_timer;
  logic                        gap;       // Chip-select spacing running
  logic                        second;    // frame_b still waiting
  logic [BIT_W-1:0]            bit_cnt;   // Bits left after the current one
  logic [2*SPI_FRAME_BITS-1:0] shift_reg; // frame_a then frame_b, MSB first
  logic                        start_gap;
  logic                        gap_end;
  logic                        frame_end;

  assign start_gap = frames_load || (frame_end && second);
  assign gap_end   = gap && cs_timer == '0;
  assign frame_end = !n_cs && bit_cnt == '0; // Last bit on the wire
  assign mosi      = shift_reg[2*SPI_FRAME_BITS-1];

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      cs_timer   <= '0;
      gap        <= 1'b0;
      second     <= 1'b0;
      n_cs       <= 1'b1;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= frame_end;
      // n_cs high CS_HIGH_CYCLES+1 cycles before each frame
      if (start_gap) begin
        gap      <= 1'b1;
        cs_timer <= TIMER_W'(CS_HIGH_CYCLES);
        second   <= frames_load;
      end else if (gap_end) begin
        gap <= 1'b0;
      end else if (gap) begin
        cs_timer <= cs_timer - 1'b1;
      end
      // 24 cycles low per frame
      if (gap_end && !start_gap) begin
        n_cs    <= 1'b0;
        bit_cnt <= BIT_W'(SPI_FRAME_BITS - 1);
      end else if (frame_end) begin
        n_cs <= 1'b1;
      end else if (!n_cs) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  // Shift on every low cycle, the last shift brings frame_b up
  always_ff @(posedge clk) begin
    if (!resetn) shift_reg <= '0;
    else if (frames_load) shift_reg <= {frame_a, frame_b};
    else if (!n_cs) shift_reg <= shift_reg << 1;
  end

endmodule

// File: verilog/dac_value_pipe.sv
`timescale 1ns/1ps

module dac_value_pipe (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     in_error,
  input  dac_ctrl_pkg::cmd_word_t  cmd_word,
  input  logic                     cmd_buf_empty,
  input  logic                     dac_wr_start,
  input  dac_ctrl_pkg::cal_table_t cal_vals,
  input  logic                     frame_done,
  output logic                     pair_req,
  output logic                     frames_load,
  output dac_ctrl_pkg::spi_frame_t frame_a,
  output dac_ctrl_pkg::spi_frame_t frame_b,
  output logic                     dac_wr_done,
  output dac_ctrl_pkg::abs_val_t [7:0] abs_vals,
  output logic                     dac_val_oob
);
  import dac_ctrl_pkg::*;

  dac_chan_t          chan;   // Channel of the frame on the wire
  dac_chan_t          chan_a; // Even channel of the pair in flight
  dac_chan_t          chan_b;
  dac_code_t          raw_a;
  dac_code_t          raw_b;
  logic               raw_bad;
  logic               sum_bad;
  logic               load_v; // Stage valids
  logic               cal_v;
  logic signed [15:0] sig_a;
  logic signed [15:0] sig_b;
  logic signed [16:0] sum_a;  // Extra bit so overflow is visible
  logic signed [16:0] sum_b;

  function automatic abs_val_t to_abs(input logic signed [16:0] v);
    logic signed [16:0] mag;
    mag = (v < 0) ? -v : v;
    return mag[14:0];
  endfunction

  function automatic logic out_of_range(input logic signed [16:0] v);
    return (v > 17'sd32767) || (v < -17'sd32767);
  endfunction

  // Back to offset code
  function automatic dac_code_t to_offset(input logic signed [16:0] v);
    logic signed [16:0] off;
    off = v + 17'sd32767;
    return off[15:0];
  endfunction

  assign chan_a  = {chan[2:1], 1'b0};
  assign chan_b  = {chan[2:1], 1'b1};
  assign raw_a   = cmd_word[15:0];  // Low half is the even channel
  assign raw_b   = cmd_word[31:16];
  assign raw_bad = (raw_a == 16'hFFFF) || (raw_b == 16'hFFFF); // Not a legal code
  assign sum_bad = out_of_range(sum_a) || out_of_range(sum_b);

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      chan        <= '0;
      pair_req    <= 1'b0;
      load_v      <= 1'b0;
      cal_v       <= 1'b0;
      frames_load <= 1'b0;
      dac_wr_done <= 1'b0;
    end else begin
      if (dac_wr_start) chan <= '0;
      else if (frame_done) chan <= chan + 1'b1;
      // Next pair after each odd frame, none after channel 7
      pair_req    <= dac_wr_start || (frame_done && chan[0] && chan != 3'd7);
      load_v      <= pair_req && !cmd_buf_empty && !raw_bad;
      cal_v       <= load_v;
      frames_load <= cal_v && !sum_bad;
      dac_wr_done <= frame_done && chan == 3'd7;
    end
  end

  // Load, calibrate, frame
  always_ff @(posedge clk) begin
    if (pair_req) begin
      sig_a <= raw_a - DAC_MID;
      sig_b <= raw_b - DAC_MID;
    end
    if (load_v) begin
      sum_a <= sig_a + $signed(cal_vals[chan_a]);
      sum_b <= sig_b + $signed(cal_vals[chan_b]);
    end
    if (cal_v) begin
      frame_a <= '{cmd: SPI_CMD_REG_WRITE, zero: 1'b0, chan: chan_a, value: to_offset(sum_a)};
      frame_b <= '{cmd: SPI_CMD_REG_WRITE, zero: 1'b0, chan: chan_b, value: to_offset(sum_b)};
    end
  end

  // Magnitudes, picked up by the top level after ldac
  always_ff @(posedge clk) begin
    if (!resetn) begin
      abs_vals <= '0;
    end else if (cal_v && !sum_bad) begin
      abs_vals[chan_a] <= to_abs(sum_a);
      abs_vals[chan_b] <= to_abs(sum_b);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) dac_val_oob <= 1'b0;
    else if ((pair_req && !cmd_buf_empty && raw_bad) || (cal_v && sum_bad)) dac_val_oob <= 1'b1;
  end

endmodule
